//--- rtl/radio_pkg.sv
package radio_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int SAMPLE_W  = 32;  // packed i/q, i in the upper half
   localparam int COMP_W    = 16;  // one i or q component
   localparam int SR_ADDR_W = 8;
   localparam int SR_DATA_W = 32;
   localparam int RB_DATA_W = 64;
   localparam int MAP_W     = 3;   // swap, invert i, invert q
   localparam int OVF_CNT_W = 16;  // overflow counter, fits rb status bits 47:32

   // --------------------------------------------------
   // settings bus addresses
   // --------------------------------------------------
   localparam logic [SR_ADDR_W-1:0] SR_DB_BASE    = 8'd160;
   localparam logic [SR_ADDR_W-1:0] SR_RX_FE_BASE = SR_DB_BASE + 8'd64;

   // offsets from the rx front-end base
   // mapping: bit 0 swap i/q, bit 1 invert i, bit 2 invert q
   localparam logic [SR_ADDR_W-1:0] SR_RX_FE_MAPPING   = 8'd0;
   // dc offset: i in 31:16, q in 15:0
   localparam logic [SR_ADDR_W-1:0] SR_RX_FE_DC_OFFSET = 8'd1;

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   localparam logic [SR_ADDR_W-1:0] RB_DB_BASE = 8'd16;

   // status: level in 15:0, overflow count in 47:32
   // config: mapping in 2:0, dc offset in 63:32
   typedef enum logic [SR_ADDR_W-1:0] {
      RB_STATUS = RB_DB_BASE,
      RB_CONFIG = RB_DB_BASE + 8'd1
   } rb_sel_e;

endpackage

//--- rtl/rx_fe_settings.sv
`timescale 1ns/1ps

module rx_fe_settings #(
   parameter int FIFO_DEPTH = 16,
   parameter logic [radio_pkg::SR_ADDR_W-1:0] SR_BASE = radio_pkg::SR_RX_FE_BASE
) (
   input  logic                              radio_clk,
   input  logic                              i_rst,
   // settings write
   input  logic                              i_set_stb,
   input  logic [radio_pkg::SR_ADDR_W-1:0]   i_set_addr,
   input  logic [radio_pkg::SR_DATA_W-1:0]   i_set_data,
   // readback
   input  logic                              i_rb_stb,
   input  radio_pkg::rb_sel_e                i_rb_addr,
   input  logic [$clog2(FIFO_DEPTH):0]       i_fifo_level,
   input  logic [radio_pkg::OVF_CNT_W-1:0]   i_overflow_cnt,
   // correction settings to the front end
   output logic                              o_swap_iq,
   output logic                              o_invert_i,
   output logic                              o_invert_q,
   output logic [radio_pkg::COMP_W-1:0]      o_dc_offset_i,
   output logic [radio_pkg::COMP_W-1:0]      o_dc_offset_q,
   output logic [radio_pkg::RB_DATA_W-1:0]   o_rb_data
);

   localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;
   localparam int CW    = radio_pkg::COMP_W;

   localparam logic [radio_pkg::SR_ADDR_W-1:0] MAP_ADDR =
      SR_BASE + radio_pkg::SR_RX_FE_MAPPING;
   localparam logic [radio_pkg::SR_ADDR_W-1:0] DC_ADDR =
      SR_BASE + radio_pkg::SR_RX_FE_DC_OFFSET;

   logic [radio_pkg::MAP_W-1:0]     mapping;
   logic [radio_pkg::SR_DATA_W-1:0] dc_offset;
   logic [radio_pkg::RB_DATA_W-1:0] status_word;
   logic [radio_pkg::RB_DATA_W-1:0] config_word;

   // --------------------------------------------------
   // settings registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         mapping   <= '0;  // pass-through
         dc_offset <= '0;
      end else if (i_set_stb) begin
         if (i_set_addr == MAP_ADDR)
            mapping <= i_set_data[radio_pkg::MAP_W-1:0];
         if (i_set_addr == DC_ADDR)
            dc_offset <= i_set_data;
      end
   end

   assign o_swap_iq     = mapping[0];
   assign o_invert_i    = mapping[1];
   assign o_invert_q    = mapping[2];
   assign o_dc_offset_i = dc_offset[2*CW-1:CW];
   assign o_dc_offset_q = dc_offset[CW-1:0];

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   always_comb begin
      status_word = '0;
      status_word[LVL_W-1:0] = i_fifo_level;
      status_word[32 +: radio_pkg::OVF_CNT_W] = i_overflow_cnt;
      config_word = '0;
      config_word[radio_pkg::MAP_W-1:0] = mapping;
      config_word[63:32] = dc_offset;
   end

   // held until the next request
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_data <= '0;
      end else if (i_rb_stb) begin
         case (i_rb_addr)
            radio_pkg::RB_STATUS: o_rb_data <= status_word;
            radio_pkg::RB_CONFIG: o_rb_data <= config_word;
            default:              o_rb_data <= '0;  // unmapped reads zero
         endcase
      end
   end

endmodule

//--- rtl/rx_frontend.sv
`timescale 1ns/1ps

module rx_frontend (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   input  logic                            i_rx_stb,
   input  logic [radio_pkg::SAMPLE_W-1:0]  i_rx_data,
   input  logic                            i_swap_iq,
   input  logic                            i_invert_i,
   input  logic                            i_invert_q,
   input  logic [radio_pkg::COMP_W-1:0]    i_dc_offset_i,
   input  logic [radio_pkg::COMP_W-1:0]    i_dc_offset_q,
   output logic                            o_stb,
   output logic [radio_pkg::SAMPLE_W-1:0]  o_data
);

   localparam int CW = radio_pkg::COMP_W;
   localparam int SW = radio_pkg::SAMPLE_W;
   localparam logic [CW-1:0] MAX_VAL = {1'b0, {(CW-1){1'b1}}};
   localparam logic [CW-1:0] MIN_VAL = {1'b1, {(CW-1){1'b0}}};

   // two's complement negate, -32768 has no positive twin
   function automatic logic [CW-1:0] neg_sat(input logic [CW-1:0] x);
      if (x == MIN_VAL)
         return MAX_VAL;
      return -x;
   endfunction

   // signed subtract clipped to 16 bits
   function automatic logic [CW-1:0] sub_sat(input logic [CW-1:0] x,
                                             input logic [CW-1:0] off);
      logic [CW:0] diff;
      diff = {x[CW-1], x} - {off[CW-1], off};
      if (diff[CW] != diff[CW-1])
         return diff[CW] ? MIN_VAL : MAX_VAL;
      return diff[CW-1:0];
   endfunction

   logic [CW-1:0] ival_sw, qval_sw;
   logic [CW-1:0] ival_inv, qval_inv;

   // --------------------------------------------------
   // swap, invert, offset
   // --------------------------------------------------
   always_comb begin
      ival_sw  = i_swap_iq ? i_rx_data[CW-1:0] : i_rx_data[SW-1:CW];
      qval_sw  = i_swap_iq ? i_rx_data[SW-1:CW] : i_rx_data[CW-1:0];
      ival_inv = i_invert_i ? neg_sat(ival_sw) : ival_sw;
      qval_inv = i_invert_q ? neg_sat(qval_sw) : qval_sw;
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst)
         o_stb <= 1'b0;
      else
         o_stb <= i_rx_stb;  // fixed one cycle latency
   end

   always_ff @(posedge radio_clk) begin
      if (i_rx_stb)
         o_data <= {sub_sat(ival_inv, i_dc_offset_i), sub_sat(qval_inv, i_dc_offset_q)};
   end

endmodule

//--- rtl/rx_sample_fifo.sv
`timescale 1ns/1ps

module rx_sample_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                             radio_clk,
   input  logic                             i_rst,
   input  logic                             i_wr_stb,
   input  logic [radio_pkg::SAMPLE_W-1:0]   i_wr_data,
   input  logic                             i_rd_stb,
   output logic [radio_pkg::SAMPLE_W-1:0]   o_rd_data,
   output logic                             o_empty,
   output logic [$clog2(FIFO_DEPTH):0]      o_level,
   output logic [radio_pkg::OVF_CNT_W-1:0]  o_overflow_cnt
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [radio_pkg::SAMPLE_W-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          full;
   logic          wr_en;
   logic          rd_en;

   assign full    = (o_level == FIFO_DEPTH);
   assign o_empty = (o_level == '0);
   assign wr_en   = i_wr_stb && !full;  // full judged before any read this cycle
   assign rd_en   = i_rd_stb && !o_empty;

   // show-ahead head
   assign o_rd_data = mem[rd_ptr];

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (wr_en)
         mem[wr_ptr] <= i_wr_data;
   end

   // --------------------------------------------------
   // pointers, level and overflow count
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         o_level        <= '0;
         o_overflow_cnt <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   o_level <= o_level + 1'b1;
            2'b01:   o_level <= o_level - 1'b1;
            default: o_level <= o_level;
         endcase
         // sample lost, count saturates at all ones
         if (i_wr_stb && full && !(&o_overflow_cnt))
            o_overflow_cnt <= o_overflow_cnt + 1'b1;
      end
   end

endmodule

//--- rtl/rx_stream_out.sv
`timescale 1ns/1ps

module rx_stream_out (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   input  logic                            i_run_rx,
   input  logic                            i_empty,
   input  logic [radio_pkg::SAMPLE_W-1:0]  i_head_data,
   output logic                            o_rd_stb,
   output logic                            o_rx_stb,
   output logic [radio_pkg::SAMPLE_W-1:0]  o_rx_data
);

   // pop the head whenever running and something is there
   assign o_rd_stb = i_run_rx && !i_empty;

   // --------------------------------------------------
   // output register
   // --------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst)
         o_rx_stb <= 1'b0;
      else
         o_rx_stb <= o_rd_stb;  // one cycle after the pop
   end

   always_ff @(posedge radio_clk) begin
      if (o_rd_stb)
         o_rx_data <= i_head_data;  // head is still the popped entry this cycle
   end

endmodule

//--- rtl/radio_rx_core.sv
`timescale 1ns/1ps

module radio_rx_core #(
   parameter int FIFO_DEPTH = 16,
   parameter logic [radio_pkg::SR_ADDR_W-1:0] SR_BASE = radio_pkg::SR_RX_FE_BASE
) (
   input  logic                             radio_clk,
   input  logic                             i_rst,
   // settings bus
   input  logic                             i_set_stb,
   input  logic [radio_pkg::SR_ADDR_W-1:0]  i_set_addr,
   input  logic [radio_pkg::SR_DATA_W-1:0]  i_set_data,
   // readback bus
   input  logic                             i_rb_stb,
   input  logic [radio_pkg::SR_ADDR_W-1:0]  i_rb_addr,
   output logic [radio_pkg::RB_DATA_W-1:0]  o_rb_data,
   // adc samples in
   input  logic                             i_rx_stb,
   input  logic [radio_pkg::SAMPLE_W-1:0]   i_rx_data,
   input  logic                             i_run_rx,
   // drained samples out
   output logic                             o_rx_stb,
   output logic [radio_pkg::SAMPLE_W-1:0]   o_rx_data
);

   localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

   // settings to front end
   logic                            swap_iq;
   logic                            invert_i;
   logic                            invert_q;
   logic [radio_pkg::COMP_W-1:0]    dc_offset_i;
   logic [radio_pkg::COMP_W-1:0]    dc_offset_q;

   // front end to fifo
   logic                            fe_stb;
   logic [radio_pkg::SAMPLE_W-1:0]  fe_data;

   // fifo status and head
   logic [radio_pkg::SAMPLE_W-1:0]  head_data;
   logic                            fifo_empty;
   logic [LVL_W-1:0]                fifo_level;
   logic [radio_pkg::OVF_CNT_W-1:0] overflow_cnt;
   logic                            fifo_rd_stb;

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   rx_fe_settings #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .SR_BASE    (SR_BASE)
   ) rx_fe_settings_i (
      .radio_clk      (radio_clk),
      .i_rst          (i_rst),
      .i_set_stb      (i_set_stb),
      .i_set_addr     (i_set_addr),
      .i_set_data     (i_set_data),
      .i_rb_stb       (i_rb_stb),
      .i_rb_addr      (radio_pkg::rb_sel_e'(i_rb_addr)),
      .i_fifo_level   (fifo_level),
      .i_overflow_cnt (overflow_cnt),
      .o_swap_iq      (swap_iq),
      .o_invert_i     (invert_i),
      .o_invert_q     (invert_q),
      .o_dc_offset_i  (dc_offset_i),
      .o_dc_offset_q  (dc_offset_q),
      .o_rb_data      (o_rb_data)
   );

   // --------------------------------------------------
   // sample path
   // --------------------------------------------------
   rx_frontend rx_frontend_i (
      .radio_clk     (radio_clk),
      .i_rst         (i_rst),
      .i_rx_stb      (i_rx_stb),
      .i_rx_data     (i_rx_data),
      .i_swap_iq     (swap_iq),
      .i_invert_i    (invert_i),
      .i_invert_q    (invert_q),
      .i_dc_offset_i (dc_offset_i),
      .i_dc_offset_q (dc_offset_q),
      .o_stb         (fe_stb),
      .o_data        (fe_data)
   );

   rx_sample_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) rx_sample_fifo_i (
      .radio_clk      (radio_clk),
      .i_rst          (i_rst),
      .i_wr_stb       (fe_stb),
      .i_wr_data      (fe_data),
      .i_rd_stb       (fifo_rd_stb),
      .o_rd_data      (head_data),
      .o_empty        (fifo_empty),
      .o_level        (fifo_level),
      .o_overflow_cnt (overflow_cnt)
   );

   rx_stream_out rx_stream_out_i (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_run_rx    (i_run_rx),
      .i_empty     (fifo_empty),
      .i_head_data (head_data),
      .o_rd_stb    (fifo_rd_stb),
      .o_rx_stb    (o_rx_stb),
      .o_rx_data   (o_rx_data)
   );

endmodule

//--- verif/radio_rx_checker.sv
`timescale 1ns/1ps

module radio_rx_checker (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   input  logic                            i_rx_stb,
   input  logic [radio_pkg::SAMPLE_W-1:0]  i_rx_data
);

   logic [radio_pkg::SAMPLE_W-1:0] expect_q [$];  // oldest first
   logic [radio_pkg::SAMPLE_W-1:0] exp_val;
   int error_count = 0;
   int match_count = 0;
   int stb_count   = 0;  // every o_rx_stb seen

   task automatic push_expected(input logic [radio_pkg::SAMPLE_W-1:0] value);
      expect_q.push_back(value);
   endtask

   // drop whatever is still outstanding
   task automatic flush_expected();
      expect_q.delete();
   endtask

   function automatic int pending();
      return expect_q.size();
   endfunction

   // --------------------------------------------------
   // compare each drained sample
   // --------------------------------------------------
   always @(posedge radio_clk) begin
      if (!i_rst && i_rx_stb) begin
         stb_count++;
         if (expect_q.size() == 0) begin
            $display("At time %0t a sample came out of o_rx_data although none was expected",
                     $time);
            error_count++;
         end else begin
            exp_val = expect_q.pop_front();
            if (i_rx_data !== exp_val) begin
               $display("Error at time %0t: o_rx_data expected %h, got %h",
                        $time, exp_val, i_rx_data);
               error_count++;
            end else begin
               match_count++;
            end
         end
      end
   end

endmodule

//--- verif/radio_rx_core_tb.sv
`timescale 1ns/1ps

module radio_rx_core_tb;

   localparam int FIFO_DEPTH    = 16;
   localparam int DRAIN_TIMEOUT = 400;  // cycles
   localparam logic [7:0] MAP_ADDR = radio_pkg::SR_RX_FE_BASE + radio_pkg::SR_RX_FE_MAPPING;
   localparam logic [7:0] DC_ADDR  = radio_pkg::SR_RX_FE_BASE + radio_pkg::SR_RX_FE_DC_OFFSET;

   logic        radio_clk;
   logic        i_rst;
   logic        i_set_stb;
   logic        i_rb_stb;
   logic        i_rx_stb;
   logic        i_run_rx;
   logic [7:0]  i_set_addr;
   logic [7:0]  i_rb_addr;
   logic [31:0] i_set_data;
   logic [31:0] i_rx_data;
   logic [63:0] o_rb_data;
   logic [63:0] rb_word;
   logic        o_rx_stb;
   logic [31:0] o_rx_data;

   integer      seed = 32'h1f00_694d;
   logic [2:0]  map_shadow;  // last written configuration
   logic [31:0] dc_shadow;
   logic [31:0] dc_vals [4] = '{32'h7fff_8000, 32'h8000_7fff, 32'h0100_ff00, 32'h4000_c000};
   int tb_errors = 0;
   int checks    = 0;
   int test_num  = 0;
   int tests_bad = 0;
   int errs_at_start;
   int stb_base;

   radio_rx_core #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .SR_BASE    (radio_pkg::SR_RX_FE_BASE)
   ) radio_rx_core_i (
      .radio_clk  (radio_clk),
      .i_rst      (i_rst),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_rb_stb   (i_rb_stb),
      .i_rb_addr  (i_rb_addr),
      .o_rb_data  (o_rb_data),
      .i_rx_stb   (i_rx_stb),
      .i_rx_data  (i_rx_data),
      .i_run_rx   (i_run_rx),
      .o_rx_stb   (o_rx_stb),
      .o_rx_data  (o_rx_data)
   );

   radio_rx_checker radio_rx_checker_i (
      .radio_clk (radio_clk),
      .i_rst     (i_rst),
      .i_rx_stb  (o_rx_stb),
      .i_rx_data (o_rx_data)
   );

   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk;
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   function automatic int clamp16(input int v);
      if (v > 32767) return 32767;
      if (v < -32768) return -32768;
      return v;
   endfunction

   function automatic logic [31:0] fe_model(input logic [31:0] smp, input logic [2:0] map,
                                            input logic [31:0] dc);
      int ival, qval, tmp;
      ival = $signed(smp[31:16]);
      qval = $signed(smp[15:0]);
      if (map[0]) begin
         tmp  = ival;
         ival = qval;
         qval = tmp;
      end
      if (map[1]) ival = clamp16(-ival);
      if (map[2]) qval = clamp16(-qval);
      ival = clamp16(ival - $signed(dc[31:16]));  // offsets are signed
      qval = clamp16(qval - $signed(dc[15:0]));
      return {ival[15:0], qval[15:0]};
   endfunction

   function automatic int total_errors();
      return tb_errors + radio_rx_checker_i.error_count;
   endfunction

   task automatic check_equal(input string sig, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (act !== exp) begin
         $display("Error at time %0t: %s expected %h, got %h", $time, sig, exp, act);
         tb_errors++;
      end
   endtask

   task automatic finish_run();
      $display("tests %0d, with errors %0d, value checks %0d, samples matched %0d, errors %0d",
               test_num, tests_bad, checks, radio_rx_checker_i.match_count, total_errors());
      if (total_errors() == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (total_errors() == errs_at_start) begin
         $display("test %0d %s: ok", test_num, name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, name, total_errors() - errs_at_start);
         tests_bad++;
      end
      errs_at_start = total_errors();
   endtask

   // --------------------------------------------------
   // bus and sample drivers
   // --------------------------------------------------
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge radio_clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge radio_clk);
      i_set_stb  <= 1'b0;
   endtask

   task automatic read_back(input logic [7:0] addr, output logic [63:0] data);
      @(posedge radio_clk);
      i_rb_stb  <= 1'b1;
      i_rb_addr <= addr;
      @(posedge radio_clk);
      i_rb_stb  <= 1'b0;
      @(posedge radio_clk);
      data = o_rb_data;  // registered the edge before
   endtask

   task automatic drive_sample(input logic [31:0] data, input bit expect_out);
      @(posedge radio_clk);
      i_rx_stb  <= 1'b1;
      i_rx_data <= data;
      if (expect_out)
         radio_rx_checker_i.push_expected(fe_model(data, map_shadow, dc_shadow));
   endtask

   task automatic send_random(input int n);
      logic [31:0] data;
      repeat (n) begin
         data = $random(seed);
         drive_sample(data, 1'b1);
      end
   endtask

   task automatic stop_samples();
      @(posedge radio_clk);
      i_rx_stb <= 1'b0;
   endtask

   task automatic wait_drain();
      int cnt;
      cnt = 0;
      stop_samples();
      while (radio_rx_checker_i.pending() != 0 && cnt < DRAIN_TIMEOUT) begin
         @(negedge radio_clk);
         cnt++;
      end
      if (radio_rx_checker_i.pending() != 0) begin
         $display("Timeout: %0d expected samples never came out of the channel",
                  radio_rx_checker_i.pending());
         tb_errors++;
         radio_rx_checker_i.flush_expected();
      end
   endtask

   initial begin
      i_set_stb  = 1'b0;
      i_rb_stb   = 1'b0;
      i_rx_stb   = 1'b0;
      i_set_addr = '0;
      i_rb_addr  = '0;
      i_set_data = '0;
      i_rx_data  = '0;
      i_run_rx   = 1'b1;
      map_shadow = '0;
      dc_shadow  = '0;
      i_rst      = 1'b1;
      repeat (16) @(posedge radio_clk);
      i_rst <= 1'b0;
      errs_at_start = 0;

      send_random(40);  // pass-through after reset
      wait_drain();
      end_test("pass-through");

      for (int m = 1; m < 8; m++) begin
         write_setting(MAP_ADDR, m);
         map_shadow = m[2:0];
         drive_sample(32'h8000_8000, 1'b1);  // most negative on both
         drive_sample(32'h8000_7fff, 1'b1);
         send_random(8);
         wait_drain();
      end
      end_test("iq mapping");

      write_setting(MAP_ADDR, 32'h3);
      map_shadow = 3'b011;
      foreach (dc_vals[k]) begin
         write_setting(DC_ADDR, dc_vals[k]);
         dc_shadow = dc_vals[k];
         drive_sample(32'h8000_7fff, 1'b1);
         drive_sample(32'h7fff_8000, 1'b1);
         send_random(6);
         wait_drain();
      end
      write_setting(DC_ADDR + 8'd1, 32'hffff_ffff);  // unused offset
      write_setting(radio_pkg::SR_DB_BASE, 32'hffff_ffff);
      send_random(8);
      wait_drain();
      end_test("dc offset");

      @(posedge radio_clk);
      i_run_rx <= 1'b0;
      stb_base = radio_rx_checker_i.stb_count;
      for (int k = 0; k < FIFO_DEPTH + 5; k++)
         drive_sample($random(seed), k < FIFO_DEPTH);  // the last 5 are dropped
      stop_samples();
      repeat (2 * FIFO_DEPTH) @(posedge radio_clk);
      check_equal("o_rx_stb pulses", stb_base, radio_rx_checker_i.stb_count);
      read_back(radio_pkg::RB_STATUS, rb_word);
      check_equal("o_rb_data level", FIFO_DEPTH, rb_word[15:0]);
      check_equal("o_rb_data overflow", 5, rb_word[47:32]);
      @(posedge radio_clk);
      i_run_rx <= 1'b1;
      wait_drain();
      read_back(radio_pkg::RB_STATUS, rb_word);
      check_equal("o_rx_stb pulses", stb_base + FIFO_DEPTH, radio_rx_checker_i.stb_count);
      check_equal("o_rb_data level", 0, rb_word[15:0]);
      end_test("fifo overflow");

      read_back(radio_pkg::RB_CONFIG, rb_word);
      check_equal("o_rb_data config", {dc_shadow, 29'b0, map_shadow}, rb_word);
      read_back(8'd18, rb_word);  // unmapped
      check_equal("o_rb_data unused", 64'd0, rb_word);
      end_test("readback");

      finish_run();
   end

endmodule

//--- sim.f
rtl/radio_pkg.sv
rtl/rx_fe_settings.sv
rtl/rx_frontend.sv
rtl/rx_sample_fifo.sv
rtl/rx_stream_out.sv
rtl/radio_rx_core.sv
verif/radio_rx_checker.sv
verif/radio_rx_core_tb.sv

//--- Bender.yml
package:
  name: radio_rx_core

sources:
  - rtl/radio_pkg.sv
  - rtl/rx_fe_settings.sv
  - rtl/rx_frontend.sv
  - rtl/rx_sample_fifo.sv
  - rtl/rx_stream_out.sv
  - rtl/radio_rx_core.sv
  - target: simulation
    files:
      - verif/radio_rx_checker.sv
      - verif/radio_rx_core_tb.sv
